// File: verilog/rdreq_pkg.sv
// shared widths and structs; enabled_channels is a build-time mask, max read fixed at 512 bytes
package rdreq_pkg;

   localparam int num_channels = 4;                  // channel slots in the mux
   // slots actually built, others tie off
   localparam logic [num_channels-1:0] enabled_channels = 4'b0101;
   localparam int tag_low_bits = 3;                  // per-channel free tag part
   localparam int block_addr_bits = 55;              // byte address [63:9]
   localparam int block_count_bits = 13;             // blocks per command
   localparam int read_length_dw = 128;              // 512 byte read, in dwords

   // one command as loaded into a channel
   typedef struct packed {
      logic [block_addr_bits-1:0] block_addr;        // first block
      logic [block_count_bits-1:0] block_count;      // zero means nothing to do
   } rd_cmd_t;

   // granted request, arbiter to formatter
   typedef struct packed {
      logic [block_addr_bits-1:0] block_addr;
      logic [1:0] channel;                           // slot that won
      logic [tag_low_bits-1:0] tag_low;              // tag sampled at grant
   } rd_req_t;

   // one 64-bit beat on the output stream
   typedef struct packed {
      logic only_low_dw;   // 3DW tail, upper dword unused
      logic last;          // second beat of the header
      logic [63:0] data;   // lower dword goes first on the link
   } tlp_beat_t;

endpackage

// File: verilog/rdreq_channel.sv
// one command at a time; a load while busy overwrites the running command
`timescale 1ns/1ps

module rdreq_channel
   import rdreq_pkg::*;
(
   input  logic clock,
   input  logic reset,
   input  logic load,                             // one-cycle command strobe
   input  rd_cmd_t cmd,
   input  logic advance,                          // block granted this cycle
   output logic idle,                             // may take a new command
   output logic pending,                          // blocks left to request
   output logic [block_addr_bits-1:0] block_addr
);

   logic [block_count_bits-1:0] count;
   logic [block_count_bits-1:0] count_next;

   // next count, load wins over advance
   always_comb
   begin
      if (load)
         count_next = cmd.block_count;
      else
         count_next = count - block_count_bits'(advance);
   end

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         count <= '0;
         idle <= 1'b1;
         pending <= 1'b0;
      end
      else
      begin
         count <= count_next;
         idle <= (count_next == '0);     // drops the cycle after load
         pending <= (count != '0);       // lags count by one cycle
      end
   end

   // address stepper, payload only
   always_ff @(posedge clock)
   begin
      if (load)
         block_addr <= cmd.block_addr;
      else
         block_addr <= block_addr + block_addr_bits'(advance);  // one block = 512 bytes
   end

endmodule

// File: verilog/rdreq_arbiter.sv
// round robin over enabled slots, one slot looked at per idle cycle; one request in flight
`timescale 1ns/1ps

module rdreq_arbiter
   import rdreq_pkg::*;
(
   input  logic clock,
   input  logic reset,
   input  logic [num_channels-1:0] pending,
   input  logic [block_addr_bits-1:0] block_addr [num_channels],
   input  logic [num_channels-1:0] tag_valid,
   input  logic [tag_low_bits-1:0] tag_low [num_channels],
   output logic [num_channels-1:0] advance,       // also the tag_taken pulse
   output logic req_valid,
   output rd_req_t req,
   input  logic req_done                          // formatter took the last beat
);

   logic [1:0] ptr;     // slot under examination
   logic grant;

   // next built slot after from, wraps around
   function automatic logic [1:0] next_enabled(input logic [1:0] from);
      logic [1:0] slot;
      logic found;
      found = 1'b0;
      next_enabled = from;
      for (int k = 1; k <= num_channels; k++)
      begin
         slot = from + k[1:0];
         if (!found && enabled_channels[slot])
         begin
            next_enabled = slot;
            found = 1'b1;
         end
      end
   endfunction

   // grant needs work and a free tag on the current slot
   assign grant = !req_valid && pending[ptr] && tag_valid[ptr];
   assign advance = grant ? (num_channels'(1) << ptr) : '0;

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         ptr <= next_enabled(2'(num_channels - 1));  // first built slot
         req_valid <= 1'b0;
      end
      else if (req_valid)
      begin
         if (req_done)
         begin
            req_valid <= 1'b0;
            ptr <= next_enabled(ptr);   // resume after the served slot
         end
      end
      else if (grant)
         req_valid <= 1'b1;             // ptr holds on the winner
      else
         ptr <= next_enabled(ptr);
   end

   // request latch, stable until req_done
   always_ff @(posedge clock)
   begin
      if (grant)
      begin
         req.block_addr <= block_addr[ptr];
         req.channel <= ptr;
         req.tag_low <= tag_low[ptr];
      end
   end

endmodule

// File: verilog/rdreq_tlp_formatter.sv
// memory read headers only, all-ones byte enables, length fixed at read_length_dw
`timescale 1ns/1ps

module rdreq_tlp_formatter
   import rdreq_pkg::*;
(
   input  logic clock,
   input  logic reset,
   input  logic req_valid,
   input  rd_req_t req,
   input  logic [15:0] requester_id,
   output logic req_done,
   output logic tlp_valid,
   output tlp_beat_t tlp,
   input  logic tlp_ready
);

   logic beat;                 // 0 = dw0/dw1, 1 = address
   logic [63:0] byte_addr;
   logic four_dw;
   logic [7:0] tag;
   logic [31:0] dw0, dw1, dw2, dw3;

   assign byte_addr = {req.block_addr, 9'd0};
   assign four_dw = (byte_addr[63:32] != 32'd0);         // above 4 GB
   assign tag = {2'b00, req.channel, 1'b0, req.tag_low};

   // fmt 000/001 no data, type 00000 memory read
   assign dw0 = {2'b00, four_dw, 5'b00000, 14'd0, 10'(read_length_dw)};
   assign dw1 = {requester_id, tag, 8'hff};              // last and first BE all ones
   assign dw2 = four_dw ? byte_addr[63:32] : byte_addr[31:0];
   assign dw3 = byte_addr[31:0];                         // unused for 3DW

   assign req_done = tlp_valid && tlp_ready && beat;

   always_ff @(posedge clock)
   begin
      if (reset)
      begin
         tlp_valid <= 1'b0;
         beat <= 1'b0;
      end
      else if (!tlp_valid)
         tlp_valid <= req_valid;         // beat 0 next cycle
      else if (tlp_ready)
      begin
         beat <= !beat;
         tlp_valid <= !beat;             // drop after the address beat
      end
   end

   // beat payload, held while tlp_ready is low
   always_ff @(posedge clock)
   begin
      if (!tlp_valid && req_valid)
         tlp <= '{only_low_dw: 1'b0, last: 1'b0, data: {dw1, dw0}};
      else if (tlp_valid && tlp_ready && !beat)
         tlp <= '{only_low_dw: !four_dw, last: 1'b1, data: {dw3, dw2}};
   end

endmodule

// File: verilog/rdreq_mux.sv
// slots missing from enabled_channels never become ready; tag_low must hold while tag_valid is high
`timescale 1ns/1ps

module rdreq_mux
   import rdreq_pkg::*;
(
   input  logic clock,
   input  logic reset,
   input  logic [num_channels-1:0] cmd_load,      // per-channel strobe
   input  rd_cmd_t cmd,                           // shared by all slots
   output logic [num_channels-1:0] cmd_ready,
   input  logic [15:0] requester_id,
   input  logic [num_channels-1:0] tag_valid,
   input  logic [tag_low_bits-1:0] tag_low [num_channels],
   output logic [num_channels-1:0] tag_taken,
   output logic tlp_valid,
   output tlp_beat_t tlp,
   input  logic tlp_ready
);

   logic [num_channels-1:0] pending;
   logic [num_channels-1:0] advance;
   logic [block_addr_bits-1:0] block_addr [num_channels];
   logic req_valid;
   logic req_done;
   rd_req_t req;

   assign tag_taken = advance;   // a grant consumes the tag

   for (genvar i = 0; i < num_channels; i++)
   begin : g_slot
      if (enabled_channels[i])
      begin : g_on
         rdreq_channel channel0 (
            .clock      (clock),
            .reset      (reset),
            .load       (cmd_load[i]),
            .cmd        (cmd),
            .advance    (advance[i]),
            .idle       (cmd_ready[i]),
            .pending    (pending[i]),
            .block_addr (block_addr[i])
         );
      end
      else
      begin : g_off
         // unbuilt slot, never ready or pending
         assign cmd_ready[i] = 1'b0;
         assign pending[i] = 1'b0;
         assign block_addr[i] = '0;
      end
   end

   rdreq_arbiter arbiter0 (
      .clock      (clock),
      .reset      (reset),
      .pending    (pending),
      .block_addr (block_addr),
      .tag_valid  (tag_valid),
      .tag_low    (tag_low),
      .advance    (advance),
      .req_valid  (req_valid),
      .req        (req),
      .req_done   (req_done)
   );

   rdreq_tlp_formatter formatter0 (
      .clock        (clock),
      .reset        (reset),
      .req_valid    (req_valid),
      .req          (req),
      .requester_id (requester_id),
      .req_done     (req_done),
      .tlp_valid    (tlp_valid),
      .tlp          (tlp),
      .tlp_ready    (tlp_ready)
   );

endmodule

// File: dv/rdreq_mux_props.sv
// bound into rdreq_mux, sees its ports only; failures counter is read by the testbench
`timescale 1ns/1ps

module rdreq_mux_props
   import rdreq_pkg::*;
(
   input logic clock,
   input logic reset,
   input logic [num_channels-1:0] tag_valid,
   input logic [num_channels-1:0] tag_taken,
   input logic tlp_valid,
   input tlp_beat_t tlp,
   input logic tlp_ready
);

   int failures = 0;     // bumped by every failing assertion
   logic second_beat;    // next transfer is the address beat
   logic in_flight;      // granted but last beat not yet accepted

   always_ff @(posedge clock)
   begin
      if (reset)
         second_beat <= 1'b0;
      else if (tlp_valid && tlp_ready)
         second_beat <= !second_beat;   // toggles per accepted beat
   end

   always_ff @(posedge clock)
   begin
      if (reset)
         in_flight <= 1'b0;
      else if (tag_taken != '0)
         in_flight <= 1'b1;
      else if (tlp_valid && tlp_ready && tlp.last)
         in_flight <= 1'b0;             // header fully out
   end

   // held beat neither drops nor changes
   held_beat: assert property (@(posedge clock) disable iff (reset)
      tlp_valid && !tlp_ready |=> tlp_valid && $stable(tlp))
   else
   begin
      failures++;
      $error("beat dropped or changed while tlp_ready was low");
   end

   last_on_second: assert property (@(posedge clock) disable iff (reset)
      tlp_valid |-> (tlp.last == second_beat))   // last only on beat 1
   else
   begin
      failures++;
      $error("last flag not on the second beat of a header");
   end

   // one slot per grant and one grant per header
   tag_one_hot: assert property (@(posedge clock) disable iff (reset)
      $onehot0(tag_taken) && !(in_flight && tag_taken != '0))
   else
   begin
      failures++;
      $error("tag_taken on more than one channel or while a header was in flight");
   end

   tag_needs_valid: assert property (@(posedge clock) disable iff (reset)
      (tag_taken & ~tag_valid) == '0)            // no grant without a free tag
   else
   begin
      failures++;
      $error("tag_taken on a channel whose tag_valid was low");
   end

endmodule

// File: dv/rdreq_mux_tb.sv
// slots 0 and 2 built; tag_low held per test; needs --timing and --assert under Verilator
`timescale 1ns/1ps

module rdreq_mux_tb
   import rdreq_pkg::*;
();

   typedef struct packed {
      logic [63:0] byte_addr;
      logic four_dw;          // address above 4 GB
      logic [7:0] tag;
   } exp_hdr_t;

   logic clock;
   logic reset;
   logic [num_channels-1:0] cmd_load;
   rd_cmd_t cmd;
   logic [num_channels-1:0] cmd_ready;
   logic [15:0] requester_id;
   logic [num_channels-1:0] tag_valid;
   logic [tag_low_bits-1:0] tag_low [num_channels];
   logic [num_channels-1:0] tag_taken;
   logic tlp_valid;
   tlp_beat_t tlp;
   logic tlp_ready;

   logic [63:0] addr_q [num_channels][$];   // blocks not yet granted
   exp_hdr_t exp_q [num_channels][$];       // granted but header not yet out
   logic [1:0] chan_seq [$];                // output order of channels
   exp_hdr_t cur;                           // header between its two beats
   logic cur_ok;
   logic beat1;                             // next beat is the address beat
   logic random_ready;
   logic timed_out;
   int errors;
   int cycles;
   int cycle_limit;

   rdreq_mux dut0 (
      .clock        (clock),
      .reset        (reset),
      .cmd_load     (cmd_load),
      .cmd          (cmd),
      .cmd_ready    (cmd_ready),
      .requester_id (requester_id),
      .tag_valid    (tag_valid),
      .tag_low      (tag_low),
      .tag_taken    (tag_taken),
      .tlp_valid    (tlp_valid),
      .tlp          (tlp),
      .tlp_ready    (tlp_ready)
   );

   bind rdreq_mux rdreq_mux_props props0 (
      .clock     (clock),
      .reset     (reset),
      .tag_valid (tag_valid),
      .tag_taken (tag_taken),
      .tlp_valid (tlp_valid),
      .tlp       (tlp),
      .tlp_ready (tlp_ready)
   );

   initial
   begin
      clock = 1'b0;
      forever #10 clock = ~clock;   // 20 ns period
   end

   task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         errors++;
         $display("Mismatch %s: got %h expected %h", name, got, exp);
      end
   endtask

   // next block of channel c becomes an expected header on a grant
   task automatic take_tag(input int c);
      exp_hdr_t hdr;
      assert (addr_q[c].size() > 0)
      else
      begin
         errors++;
         $display("tag taken on channel %0d with no block left to read", c);
      end
      if (addr_q[c].size() > 0)
      begin
         hdr.byte_addr = addr_q[c].pop_front();
         hdr.four_dw = (hdr.byte_addr[63:32] != 32'd0);
         hdr.tag = {2'b00, 2'(c), 1'b0, tag_low[c]};   // channel and free tag
         exp_q[c].push_back(hdr);
      end
   endtask

   task automatic check_beat();
      logic [1:0] chan;
      logic [31:0] dw0_exp;
      if (!beat1)
      begin
         chan = tlp.data[45:44];                  // tag bits 5:4 inside dw1
         check_value("tlp.last", 64'(tlp.last), 64'd0);
         check_value("tlp.only_low_dw", 64'(tlp.only_low_dw), 64'd0);
         cur_ok = (exp_q[chan].size() > 0);
         assert (cur_ok)
         else
         begin
            errors++;
            $display("header for channel %0d that has no granted block", chan);
         end
         if (cur_ok)
         begin
            cur = exp_q[chan].pop_front();
            chan_seq.push_back(chan);
            // memory read with fmt 000 or 001 and length in dwords
            dw0_exp = {(cur.four_dw ? 3'b001 : 3'b000), 5'd0, 14'd0, 10'(read_length_dw)};
            check_value("tlp.data dw0", 64'(tlp.data[31:0]), 64'(dw0_exp));
            check_value("tlp.data dw1", 64'(tlp.data[63:32]), 64'({requester_id, cur.tag, 8'hff}));
         end
         beat1 = 1'b1;
      end
      else
      begin
         check_value("tlp.last", 64'(tlp.last), 64'd1);
         if (cur_ok)
         begin
            check_value("tlp.only_low_dw", 64'(tlp.only_low_dw), 64'(!cur.four_dw));
            if (cur.four_dw)
               check_value("tlp.data", tlp.data, {cur.byte_addr[31:0], cur.byte_addr[63:32]});
            else
               check_value("tlp.data low", 64'(tlp.data[31:0]), 64'(cur.byte_addr[31:0]));
         end
         beat1 = 1'b0;
      end
   endtask

   // output monitor samples before the DUT registers update
   always @(posedge clock)
   begin
      if (!reset)
      begin
         check_value("cmd_ready unbuilt", 64'(cmd_ready & ~enabled_channels), 64'd0);
         for (int c = 0; c < num_channels; c++)
            if (tag_taken[c])
               take_tag(c);
         if (tlp_valid && tlp_ready)
            check_beat();
      end
   end

   task automatic next_cycle();
      @(negedge clock);
      if (random_ready)
         tlp_ready = 1'($urandom_range(0, 1));   // about half the cycles stalled
      else
         tlp_ready = 1'b1;
   endtask

   task automatic load_cmd(input int c, input logic [block_addr_bits-1:0] start, input int count);
      cmd.block_addr = start;
      cmd.block_count = block_count_bits'(count);
      cmd_load = num_channels'(1) << c;
      if (enabled_channels[c])
         for (int k = 0; k < count; k++)
            addr_q[c].push_back({start + block_addr_bits'(k), 9'd0});   // 512 byte step
      next_cycle();
      cmd_load = '0;
   endtask

   function automatic bit work_left();
      bit busy;
      busy = beat1 || tlp_valid;
      for (int c = 0; c < num_channels; c++)
         busy = busy || addr_q[c].size() != 0 || exp_q[c].size() != 0;
      return busy;
   endfunction

   task automatic wait_drain();
      next_cycle();
      while (work_left())
         next_cycle();
   endtask

   task automatic new_tags();
      for (int c = 0; c < num_channels; c++)
         tag_low[c] = tag_low_bits'($urandom);
   endtask

   task automatic finish_run();
      int prop_fails;
      prop_fails = dut0.props0.failures;
      $display("errors: %0d testbench, %0d assertion", errors, prop_fails);
      if (errors == 0 && prop_fails == 0 && !timed_out)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   endtask

   always @(posedge clock)
   begin
      cycles++;
      if (cycles >= cycle_limit)
      begin
         timed_out = 1'b1;
         $display("timeout, run still busy after %0d cycles", cycle_limit);
         finish_run();
      end
   end

   initial
   begin
      logic [block_addr_bits-1:0] start;
      void'($urandom(32'h1b93_dbc3));
      errors = 0;
      cycles = 0;
      cycle_limit = 40 * (5 + 4 + 12 + 10) + 200;   // 40 per expected header
      timed_out = 1'b0;
      beat1 = 1'b0;
      cur_ok = 1'b0;
      cur = '0;
      random_ready = 1'b0;
      reset = 1'b1;
      cmd_load = '0;
      cmd = '0;
      requester_id = 16'($urandom);
      tag_valid = '0;
      tag_low = '{default: '0};
      tlp_ready = 1'b1;
      repeat (2) @(negedge clock);
      reset = 1'b0;
      next_cycle();
      check_value("tlp_valid", 64'(tlp_valid), 64'd0);
      check_value("tag_taken", 64'(tag_taken), 64'd0);
      check_value("cmd_ready", 64'(cmd_ready), 64'(enabled_channels));
      // low address on channel 0 gives 3DW headers without stalls
      tag_valid = '1;
      new_tags();
      start = block_addr_bits'($urandom_range(0, 32'h7f_ff00));
      load_cmd(0, start, 5);
      check_value("cmd_ready", 64'(cmd_ready[0]), 64'd0);   // busy from the cycle after load
      wait_drain();
      check_value("cmd_ready", 64'(cmd_ready[0]), 64'd1);
      // 4DW headers above 4 GB under random back-pressure
      random_ready = 1'b1;
      load_cmd(0, {23'($urandom) | 23'd1, 32'($urandom)}, 4);
      wait_drain();
      // two channels share the output in turn
      new_tags();
      chan_seq.delete();
      load_cmd(0, block_addr_bits'($urandom_range(0, 32'h7f_ff00)), 6);
      load_cmd(2, {23'($urandom) | 23'd1, 32'($urandom)}, 6);
      wait_drain();
      for (int i = 1; i < chan_seq.size(); i++)
         assert (chan_seq[i] != chan_seq[i-1])
         else
         begin
            errors++;
            $display("channel %0d served twice in a row at header %0d", chan_seq[i], i);
         end
      // channel 0 runs alone while channel 2 has no free tag
      tag_valid[2] = 1'b0;
      new_tags();
      load_cmd(0, block_addr_bits'($urandom_range(0, 32'h7f_ff00)), 5);
      load_cmd(2, block_addr_bits'($urandom_range(0, 32'h7f_ff00)), 5);
      while (addr_q[0].size() != 0 || exp_q[0].size() != 0 || beat1)
         next_cycle();
      check_value("channel 2 blocks left", 64'(addr_q[2].size()), 64'd5);
      tag_valid[2] = 1'b1;
      wait_drain();
      // strobes on unbuilt slots stay silent
      load_cmd(1, start, 3);
      load_cmd(3, start, 3);
      repeat (20)
      begin
         next_cycle();
         check_value("tlp_valid", 64'(tlp_valid), 64'd0);
      end
      finish_run();
   end

endmodule

// File: src.f
verilog/rdreq_pkg.sv
verilog/rdreq_channel.sv
verilog/rdreq_arbiter.sv
verilog/rdreq_tlp_formatter.sv
verilog/rdreq_mux.sv
dv/rdreq_mux_props.sv
dv/rdreq_mux_tb.sv

// File: Makefile
# Verilator build and run of rdreq_mux_tb; any variable below can be set on the command line
VERILATOR ?= verilator
TOP       ?= rdreq_mux_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= Checks failed

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, fail when the log reports failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)
